//--- mac_settings.svh
`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------

`define MAC_OP_WIDTH   16 // signed operand
`define MAC_PROD_WIDTH 32 // full signed product
`define MAC_ACC_WIDTH  40 // accumulator, wraps on overflow

// ----------------------------------------
// approximate multiplier
// ----------------------------------------

// worst case |approx - exact| for one product
// four correction words below 2^21, dropped rows below 2^22
`define MAC_APPROX_ERR_BOUND (1 << 23)

`endif

//--- mac_pkg.sv
`include "mac_settings.svh"

package mac_pkg;

    // ----------------------------------------
    // width types
    // ----------------------------------------

    typedef logic signed [`MAC_OP_WIDTH-1:0]   operand_t;
    typedef logic signed [`MAC_PROD_WIDTH-1:0] product_t;
    typedef logic signed [`MAC_ACC_WIDTH-1:0]  acc_t;

    // ----------------------------------------
    // request and response
    // ----------------------------------------

    // one MAC request, 34 bits
    typedef struct packed {
        logic     clear;  // start a new sum
        logic     approx; // approximate multiplier
        operand_t x;
        operand_t y;
    } mac_req_t;

    // one MAC result
    typedef struct packed {
        acc_t acc;
    } mac_resp_t;

endpackage

//--- xsyw_25.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

// approximate signed 16x16 Baugh-Wooley multiplier
// rows 0..5 collapse into four sparse 21-bit correction words
module xsyw_25 import mac_pkg::*; (
    input  operand_t x,
    input  operand_t y,
    output product_t z
);

    localparam int N_ROWS  = 16;   // fixed by the correction wiring
    localparam int FIRST   = 6;    // first row kept in the array
    localparam int CORR_W  = 21;
    localparam int PAD_W   = `MAC_PROD_WIDTH - CORR_W;
    localparam int ROW_PAD = `MAC_PROD_WIDTH - `MAC_OP_WIDTH;

    logic [N_ROWS-1:0][`MAC_OP_WIDTH-1:0] pp;
    logic [CORR_W-1:0]                    corr0;
    logic [CORR_W-1:0]                    corr1;
    logic [CORR_W-1:0]                    corr2;
    logic [CORR_W-1:0]                    corr3;
    logic [`MAC_PROD_WIDTH-1:0]           row_sum;

    // ----------------------------------------
    // partial product rows
    // ----------------------------------------

    genvar i;
    for (i = 0; i < N_ROWS - 1; i++) begin : g_row
        assign pp[i] = {~(y[15] & x[i]), y[14:0] & {15{x[i]}}}; // sign column inverted
    end

    // last row, magnitude bits inverted, sign-sign term plain
    assign pp[N_ROWS-1] = {x[15] & y[15], ~(y[14:0] & {15{x[15]}})};

    // ----------------------------------------
    // correction words for rows 0..5
    // ----------------------------------------

    always_comb begin
        corr0     = '0;
        corr0[1]  = pp[0][1] ^ pp[1][0];
        corr0[5]  = pp[2][3] ^ pp[3][2];
        corr0[7]  = pp[0][7] ^ pp[1][6]; // half adder sum
        corr0[8]  = pp[0][7] & pp[1][6]; // and its carry
        corr0[11] = pp[0][10] & pp[1][9];
        corr0[12] = pp[0][11] & pp[1][10];
        corr0[13] = pp[2][10] & pp[3][9];
        corr0[14] = pp[4][10] ^ pp[5][9];
        corr0[15] = pp[0][15] ^ pp[1][14];
        corr0[16] = pp[0][15] | pp[1][14];
        corr0[17] = 1'b1;                // stands in for the row 0 constant
        corr0[18] = pp[3][15];
        corr0[19] = pp[4][14] & pp[5][13];
        corr0[20] = pp[4][15] & pp[5][14];
    end

    always_comb begin
        corr1     = '0;
        corr1[7]  = pp[2][5] ^ pp[3][4];
        corr1[13] = pp[4][8] & pp[5][7];
        corr1[15] = pp[2][12] & pp[3][11];
        corr1[16] = pp[1][15];           // row 1 sign column, exact weight
        corr1[17] = pp[2][14] & pp[3][13];
        corr1[18] = pp[4][13] | pp[5][12];
        corr1[19] = pp[4][15] ^ pp[5][14];
        corr1[20] = pp[5][15];
    end

    // upper two words are almost empty
    always_comb begin
        corr2     = '0;
        corr2[16] = pp[4][12] | pp[5][11];
        corr2[17] = pp[2][15] & pp[3][14];
    end

    always_comb begin
        corr3     = '0;
        corr3[17] = pp[4][13] | pp[5][12]; // counted twice on purpose
    end

    // ----------------------------------------
    // summation of the kept rows
    // ----------------------------------------

    always_comb begin
        // constant one of the last row sits at bit 31
        row_sum = {1'b1, {(`MAC_PROD_WIDTH-1){1'b0}}};
        for (int r = FIRST; r < N_ROWS; r++) begin
            row_sum = row_sum + ({{ROW_PAD{1'b0}}, pp[r]} << r);
        end
    end

    assign z = row_sum
             + {{PAD_W{1'b0}}, corr0}
             + {{PAD_W{1'b0}}, corr1}
             + {{PAD_W{1'b0}}, corr2}
             + {{PAD_W{1'b0}}, corr3};

endmodule

//--- bw_mult_exact.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

// exact signed 16x16 Baugh-Wooley multiplier
module bw_mult_exact import mac_pkg::*; (
    input  operand_t x,
    input  operand_t y,
    output product_t z
);

    localparam int N       = `MAC_OP_WIDTH;
    localparam int ROW_PAD = `MAC_PROD_WIDTH - N;

    // correction ones at 2^n and 2^(2n-1)
    localparam logic [`MAC_PROD_WIDTH-1:0] BW_ONES =
        (`MAC_PROD_WIDTH'(1) << N) | (`MAC_PROD_WIDTH'(1) << (2 * N - 1));

    logic [N-1:0][N-1:0]        pp;
    logic [`MAC_PROD_WIDTH-1:0] sum;

    // ----------------------------------------
    // partial product rows
    // ----------------------------------------

    genvar i;
    for (i = 0; i < N - 1; i++) begin : g_row
        assign pp[i] = {~(y[N-1] & x[i]), y[N-2:0] & {(N-1){x[i]}}};
    end

    // sign row
    assign pp[N-1] = {x[N-1] & y[N-1], ~(y[N-2:0] & {(N-1){x[N-1]}})};

    // ----------------------------------------
    // summation
    // ----------------------------------------

    always_comb begin
        sum = BW_ONES;
        for (int r = 0; r < N; r++) begin
            sum = sum + ({{ROW_PAD{1'b0}}, pp[r]} << r); // row r at weight 2^r
        end
    end

    assign z = sum; // wraps mod 2^32, two's complement

endmodule

//--- mac_datapath.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

// three stage MAC: operands, product, accumulator
module mac_datapath import mac_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  mac_req_t  req,
    output logic      out_valid,
    output mac_resp_t resp
);

    localparam int SIGN_EXT = `MAC_ACC_WIDTH - `MAC_PROD_WIDTH;

    mac_req_t req_q;
    logic     valid_q1;

    product_t prod_approx;
    product_t prod_exact;
    product_t prod_sel;
    product_t prod_q;
    logic     clear_q;
    logic     valid_q2;

    acc_t     prod_ext;
    acc_t     acc_q;
    logic     valid_q3;

    // ----------------------------------------
    // stage 1, operand register
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q1 <= 1'b0;
        end else begin
            valid_q1 <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            req_q <= req;
        end
    end

    // ----------------------------------------
    // stage 2, multiply and select
    // ----------------------------------------

    xsyw_25 u_approx (
        .x (req_q.x),
        .y (req_q.y),
        .z (prod_approx)
    );

    bw_mult_exact u_exact (
        .x (req_q.x),
        .y (req_q.y),
        .z (prod_exact)
    );

    assign prod_sel = req_q.approx ? prod_approx : prod_exact;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q2 <= 1'b0;
        end else begin
            valid_q2 <= valid_q1;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q1) begin
            prod_q  <= prod_sel;
            clear_q <= req_q.clear; // travels with its product
        end
    end

    // ----------------------------------------
    // stage 3, accumulate
    // ----------------------------------------

    assign prod_ext = {{SIGN_EXT{prod_q[`MAC_PROD_WIDTH-1]}}, prod_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q    <= '0;
            valid_q3 <= 1'b0;
        end else begin
            valid_q3 <= valid_q2;
            if (valid_q2) begin
                acc_q <= clear_q ? prod_ext : acc_q + prod_ext; // 40-bit wrap
            end
        end
    end

    assign out_valid = valid_q3;
    assign resp      = '{acc: acc_q};

endmodule

//--- mac_top.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

module mac_top import mac_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  logic     clear,
    input  logic     approx,
    input  operand_t x,
    input  operand_t y,
    output logic     out_valid,
    output acc_t     acc
);

    mac_req_t  req;
    mac_resp_t resp;

    // ----------------------------------------
    // port packing
    // ----------------------------------------

    assign req = '{clear: clear, approx: approx, x: x, y: y};

    mac_datapath u_datapath (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .resp      (resp)
    );

    assign acc = resp.acc; // running sum

endmodule

//--- mac_assertions.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

// pipeline timing and reset checks on the MAC datapath
module mac_assertions import mac_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      in_valid,
    input logic      out_valid,
    input mac_resp_t resp
);

    // ----------------------------------------
    // latency
    // ----------------------------------------

    // request at edge N shows up as out_valid sampled at edge N+3
    a_latency: assert property (
        @(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, 3)
    ) else $error("out_valid does not follow in_valid by the pipeline latency");

    // ----------------------------------------
    // reset
    // ----------------------------------------

    a_reset_quiet: assert property (
        @(posedge clk)
        ($past(rst, 1) || $past(rst, 2) || $past(rst, 3)) |-> !out_valid
    ) else $error("out_valid high during or just after reset");

    // accumulator only moves with a result
    a_acc_stable: assert property (
        @(posedge clk) disable iff (rst)
        !out_valid |-> $stable(resp.acc)
    ) else $error("acc changed while out_valid was low");

endmodule

bind mac_datapath mac_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .resp      (resp)
);

//--- mac_tb.sv
`timescale 1ns/1ps
`include "mac_settings.svh"

module mac_tb import mac_pkg::*; ();

    localparam int RST_CYCLES  = 10;
    localparam int IDLE_CYCLES = 4;
    localparam int N_WRAP      = 520; // enough 2^30 terms to wrap 40 bits
    localparam int N_RAND      = 16;
    localparam int SLACK       = 20;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    logic     clear;
    logic     approx;
    operand_t x;
    operand_t y;
    logic     out_valid;
    acc_t     acc;

    // ----------------------------------------
    // stimulus table and reference state
    // ----------------------------------------

    typedef struct packed {
        logic     clear;
        logic     approx;
        operand_t x;
        operand_t y;
        int       gap;    // idle cycles after the row
    } stim_t;

    stim_t stim_q[$];
    string stim_name_q[$];

    acc_t  exp_acc_q[$];
    int    exp_terms_q[$];
    string exp_name_q[$];

    acc_t  model_acc;
    int    model_terms;    // approximate products in the current sum

    int    sent;
    int    results;
    int    tests;
    int    errors;
    int    cycles = 0;
    int    cycle_limit = 0;

    mac_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .clear     (clear),
        .approx    (approx),
        .x         (x),
        .y         (y),
        .out_valid (out_valid),
        .acc       (acc)
    );

    always #50 clk = ~clk;

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic check_acc(input string name, input acc_t expected, input acc_t actual);
        tests++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end else begin
            $display("passed %s: acc %0d", name, actual);
        end
    endtask

    task automatic check_approx(input string name, input acc_t reference, input acc_t actual,
                                input int terms);
        acc_t   diff;
        longint mag;
        longint tol;
        tests++;
        diff = actual - reference; // wraps like the accumulator
        mag  = longint'(diff);
        if (mag < 0) begin
            mag = -mag;
        end
        tol = longint'(terms) * `MAC_APPROX_ERR_BOUND;
        if ($isunknown(actual) || mag > tol) begin
            errors++;
            $display("FAILED %s: expected %0d within %0d, actual %0d",
                     name, reference, tol, actual);
        end else begin
            $display("passed %s: acc %0d, error %0d of %0d", name, actual, mag, tol);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        tests++;
        if (actual != expected) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end else begin
            $display("passed %s: %0d", name, actual);
        end
    endtask

    // ----------------------------------------
    // table, driver, monitor
    // ----------------------------------------

    task automatic add_row(input string name, input logic c, input logic a,
                           input int xv, input int yv, input int gap);
        stim_t s;
        s.clear  = c;
        s.approx = a;
        s.x      = operand_t'(xv);
        s.y      = operand_t'(yv);
        s.gap    = gap;
        stim_q.push_back(s);
        stim_name_q.push_back(name);
    endtask

    task automatic build_table();
        logic c;
        logic a;
        add_row("first_no_clear", 1'b0, 1'b0, 3, 7, 2);     // sums onto zero after reset
        add_row("ex_min_sq",      1'b1, 1'b0, -32768, -32768, 1);
        add_row("ex_neg1_sq",     1'b1, 1'b0, -1, -1, 0);
        add_row("ex_zero",        1'b1, 1'b0, 0, 12345, 0);
        add_row("ex_max_min",     1'b1, 1'b0, 32767, -32768, 3);
        add_row("ex_mixed",       1'b1, 1'b0, -1234, 567, 0);
        add_row("acc_0",          1'b1, 1'b0, 32767, 32767, 0);
        add_row("acc_1",          1'b0, 1'b0, -32768, 32767, 0);
        add_row("acc_2",          1'b0, 1'b0, -1, -32768, 1);
        add_row("acc_3",          1'b0, 1'b0, 25000, -17, 0);
        add_row("acc_4",          1'b0, 1'b0, -300, -300, 2);
        for (int i = 0; i < N_WRAP; i++) begin
            add_row($sformatf("wrap_%0d", i), (i == 0), 1'b0, -32768, -32768, 0);
        end
        add_row("ap_min_sq",      1'b1, 1'b1, -32768, -32768, 0);
        add_row("ap_max_sq",      1'b1, 1'b1, 32767, 32767, 1);
        add_row("ap_neg",         1'b1, 1'b1, -20000, 31000, 0);
        add_row("ap_small",       1'b1, 1'b1, 5, -9, 2);
        add_row("ap_zero",        1'b1, 1'b1, 0, -32768, 0);
        // mixed precision within one sum
        add_row("mix_0",          1'b1, 1'b0, 1000, 2000, 0);
        add_row("mix_1",          1'b0, 1'b1, -30000, 25000, 0);
        add_row("mix_2",          1'b0, 1'b0, 12345, -321, 1);
        add_row("mix_3",          1'b0, 1'b1, 32767, -32768, 0);
        add_row("mix_4",          1'b0, 1'b1, -4321, -8765, 3);
        for (int i = 0; i < N_RAND; i++) begin
            c = (i < 8) || (i % 4 == 0);
            a = (i < 8) || ($urandom_range(1, 0) == 1);
            add_row($sformatf("rnd_%0d", i), c, a, $urandom(), $urandom(),
                    $urandom_range(2, 0));
        end
    endtask

    task automatic apply_row(input string name, input stim_t s);
        product_t p;
        clear    = s.clear;
        approx   = s.approx;
        x        = s.x;
        y        = s.y;
        in_valid = 1'b1;
        p = product_t'(s.x) * product_t'(s.y);
        if (s.clear) begin
            model_acc   = acc_t'(p);
            model_terms = 0;
        end else begin
            model_acc = model_acc + acc_t'(p); // 40-bit wrap
        end
        if (s.approx) begin
            model_terms++;
        end
        exp_acc_q.push_back(model_acc);
        exp_terms_q.push_back(model_terms);
        exp_name_q.push_back(name);
        sent++;
        @(negedge clk);
        in_valid = 1'b0;
        repeat (s.gap) @(negedge clk);
    endtask

    task automatic reset_dut();
        rst      = 1'b1;
        in_valid = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst         = 1'b0;
        model_acc   = '0;
        model_terms = 0;
    endtask

    task automatic check_result();
        string name;
        acc_t  expected;
        int    terms;
        if (exp_acc_q.size() == 0) begin
            errors++;
            $display("out_valid raised with no request in flight, acc %0d", acc);
        end else begin
            name     = exp_name_q.pop_front();
            expected = exp_acc_q.pop_front();
            terms    = exp_terms_q.pop_front();
            if (terms == 0) begin
                check_acc(name, expected, acc);
            end else begin
                check_approx(name, expected, acc, terms);
            end
        end
        results++;
    endtask

    always @(negedge clk) begin
        if (!rst && out_valid) begin
            check_result();
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d results received",
                     cycles, results, sent);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        int budget;
        rst         = 1'b1;
        in_valid    = 1'b0;
        clear       = 1'b0;
        approx      = 1'b0;
        x           = '0;
        y           = '0;
        model_acc   = '0;
        model_terms = 0;
        sent        = 0;
        results     = 0;
        tests       = 0;
        errors      = 0;
        void'($urandom(32'hca0d));

        build_table();
        budget = 2 * RST_CYCLES + IDLE_CYCLES + 1 + SLACK;
        foreach (stim_q[i]) begin
            budget += 1 + stim_q[i].gap;
        end
        cycle_limit = budget;

        reset_dut();
        repeat (IDLE_CYCLES) @(negedge clk); // nothing may come out here

        foreach (stim_q[i]) begin
            apply_row(stim_name_q[i], stim_q[i]);
        end
        while (exp_acc_q.size() != 0) @(negedge clk);

        // second reset, then a sum without clear
        reset_dut();
        check_acc("reset_acc", '0, acc);
        apply_row("after_reset", '{clear: 1'b0, approx: 1'b0, x: operand_t'(-7),
                                   y: operand_t'(9), gap: 0});
        while (exp_acc_q.size() != 0) @(negedge clk);

        check_count("result_count", sent, results);
        $display("totals: %0d tests, %0d errors, %0d results", tests, errors, results);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
mac_pkg.sv
xsyw_25.sv
bw_mult_exact.sv
mac_datapath.sv
mac_top.sv
mac_assertions.sv
mac_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the MAC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module mac_tb \
    -o Vmac_tb

./obj_dir/Vmac_tb | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi
